// ==== Makefile ====
SIM = obj_dir/cluster_sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): tb.f logic/*.sv bench/*.sv bench/*.svh
	verilator --binary --timing --assert -f tb.f --top-module cluster_tb -o cluster_sim

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/cluster_model.svh ====
// reference model for the cluster testbench: address regions, strobe merge,
// hart value and bus addresses; included inside the testbench module
`ifndef CLUSTER_MODEL_SVH
`define CLUSTER_MODEL_SVH

localparam data_t DMEM_BASE  = 32'h1000_0000;
localparam data_t VMEM_BASE  = 32'h2000_0000;
localparam data_t NOMAP_BASE = 32'h3000_0000;  // selector 011, nothing mapped
localparam data_t PERF_BASE  = 32'h4000_0000;
localparam data_t HART_ADDR  = 32'h4000_1000;

// unmapped space behaves like video: reads zero, writes dropped
function automatic region_e expected_region(data_t addr);
    region_e r;
    if (addr[30:28] == 3'b001) begin
        r = REGION_DMEM;
    end else if (addr[30:28] == 3'b100) begin
        r = addr[12] ? REGION_HART : REGION_PERF;
    end else begin
        r = REGION_VMEM;
    end
    return r;
endfunction

function automatic int word_index(data_t addr);
    return int'(addr[DMEM_ADDR_W+1:2]);
endfunction

function automatic data_t dmem_addr(int idx);
    return DMEM_BASE + data_t'(idx * 4);
endfunction

function automatic data_t strobe_merge(data_t old, data_t wdata, strb_t strb);
    data_t res;
    for (int b = 0; b < 4; b++) begin
        res[b*8 +: 8] = strb[b] ? wdata[b*8 +: 8] : old[b*8 +: 8];
    end
    return res;
endfunction

function automatic data_t expected_hart(int core);
    return data_t'(core);  // hart index equals port position
endfunction

`endif

// ==== bench/cluster_tb.sv ====
// testbench for the cluster data-memory side: every core port runs its own
// request loop, one compare process checks results against the model
`timescale 1ns/100ps

module cluster_tb;
    import cluster_pkg::*;

    `include "cluster_model.svh"

    localparam int          NUM_CORES    = 4;
    localparam logic [31:0] SEED         = 32'ha490;
    localparam int          RESET_CYCLES = 3;
    localparam int          N_SINGLE     = 16;  // words of the single-core strobe test
    localparam int          N_WORDS      = 16;  // words owned by each core
    localparam int          N_MIXED      = 48;
    localparam int          HART_READS   = 2;
    localparam int          PERF_REQS    = 11;
    localparam int          SIDE_REQS    = 6;
    localparam int          PER_CORE     = N_WORDS + N_MIXED + HART_READS + PERF_REQS + SIDE_REQS;
    localparam int          TOTAL_REQS   = 3 * N_SINGLE + NUM_CORES * PER_CORE;
    localparam int          CYCLE_LIMIT  = TOTAL_REQS * (NUM_CORES / 2 + 4) + RESET_CYCLES;
    localparam int          DMEM_LAT_MAX = NUM_CORES / 2 + 3;  // buffer cycle plus bound
    // 0..3 write that control value, 4 reads low word, 5 reads high word
    localparam int          PERF_SEQ [PERF_REQS] = '{1, 4, 0, 4, 5, 1, 4, 4, 2, 4, 4};

    typedef struct {
        int        core;
        dbus_req_t req;
        data_t     rdata;
        int        lat;  // cycles until stall was seen low
    } result_t;

    logic                 clk_i;
    logic                 reset_i;
    dbus_req_t            dbus_req   [NUM_CORES];
    logic [NUM_CORES-1:0] dbus_stall;
    data_t                dbus_rdata [NUM_CORES];

    result_t    results [$];
    data_t      model_mem [DMEM_WORDS];
    logic [1:0] perf_mode [NUM_CORES];
    data_t      perf_last [NUM_CORES];
    logic       perf_seen [NUM_CORES];
    int         n_checks;
    int         n_errors;
    int         n_done;
    int         cores_done;
    int         cycles;

    mem_cluster #(
        .NUM_CORES (NUM_CORES)
    ) mem_cluster_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .dbus_req_i   (dbus_req),
        .dbus_stall_o (dbus_stall),
        .dbus_rdata_o (dbus_rdata)
    );

    always #5 clk_i = ~clk_i;

    task automatic check_value(input string name, input data_t got, input data_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic dbus_req_t make_req(logic we, data_t addr, data_t wdata, strb_t strb);
        dbus_req_t r;
        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        r.wstrb = strb;
        return r;
    endfunction

    // entered at a falling edge, returns at a falling edge with the port idle
    task automatic issue_request(input int c, input dbus_req_t r);
        result_t res;
        logic    stalled;
        res.core    = c;
        res.req     = r;
        res.lat     = 0;
        dbus_req[c] = r;
        do begin
            @(posedge clk_i);
            res.lat++;
            stalled   = dbus_stall[c];
            res.rdata = dbus_rdata[c];  // memory data comes with stall low
        end while (stalled);
        @(negedge clk_i);
        dbus_req[c] = '0;
        if (expected_region(r.addr) != REGION_DMEM) begin
            @(posedge clk_i);
            res.rdata = dbus_rdata[c];  // one cycle after the request
            @(negedge clk_i);
        end
        n_done++;
        results.push_back(res);
    endtask

    task automatic single_core_strobes();
        int base;
        base = DMEM_WORDS / 2;
        for (int k = 0; k < N_SINGLE; k++) begin
            issue_request(0, make_req(1'b1, dmem_addr(base + k), $urandom, 4'hf));
        end
        for (int k = 0; k < N_SINGLE; k++) begin
            issue_request(0, make_req(1'b1, dmem_addr(base + k), $urandom,
                                      strb_t'($urandom_range(1, 15))));
        end
        for (int k = 0; k < N_SINGLE; k++) begin
            issue_request(0, make_req(1'b0, dmem_addr(base + k), '0, '0));
        end
    endtask

    task automatic mixed_traffic(input int c);
        int base;
        int idx;
        base = c * 64;  // disjoint word range per core
        for (int k = 0; k < N_WORDS; k++) begin
            issue_request(c, make_req(1'b1, dmem_addr(base + k), $urandom, 4'hf));
        end
        for (int k = 0; k < N_MIXED; k++) begin
            idx = base + int'($urandom_range(0, N_WORDS - 1));
            if ($urandom_range(0, 1) == 1) begin
                issue_request(c, make_req(1'b1, dmem_addr(idx), $urandom,
                                          strb_t'($urandom_range(1, 15))));
            end else begin
                issue_request(c, make_req(1'b0, dmem_addr(idx), '0, '0));
            end
        end
    endtask

    task automatic hart_reads(input int c);
        for (int k = 0; k < HART_READS; k++) begin
            issue_request(c, make_req(1'b0, HART_ADDR, '0, '0));
        end
    endtask

    task automatic perf_sequence(input int c);
        int op;
        for (int k = 0; k < PERF_REQS; k++) begin
            op = PERF_SEQ[k];
            if (op < 4) begin
                issue_request(c, make_req(1'b1, PERF_BASE, data_t'(op), 4'hf));
            end else begin
                issue_request(c, make_req(1'b0, PERF_BASE + (op == 4 ? 32'd4 : 32'd0), '0, '0));
            end
        end
    endtask

    // video and unmapped accesses, then the data words below them must be intact
    task automatic side_ranges(input int c);
        data_t off;
        off = data_t'(c * 64 * 4);
        issue_request(c, make_req(1'b0, VMEM_BASE + off, '0, '0));
        issue_request(c, make_req(1'b1, VMEM_BASE + off, $urandom, 4'hf));
        issue_request(c, make_req(1'b0, NOMAP_BASE + off, '0, '0));
        issue_request(c, make_req(1'b1, NOMAP_BASE + off + 32'd4, $urandom, 4'hf));
        issue_request(c, make_req(1'b0, DMEM_BASE + off, '0, '0));
        issue_request(c, make_req(1'b0, DMEM_BASE + off + 32'd4, '0, '0));
    endtask

    task automatic core_phase(input int phase, input int c);
        case (phase)
            3:       mixed_traffic(c);
            4:       hart_reads(c);
            5:       perf_sequence(c);
            default: side_ranges(c);
        endcase
        cores_done++;
    endtask

    task automatic run_on_all_cores(input int phase);
        cores_done = 0;
        for (int c = 0; c < NUM_CORES; c++) begin
            fork
                automatic int cc = c;
                core_phase(phase, cc);
            join_none
        end
        while (cores_done < NUM_CORES) begin
            @(negedge clk_i);
        end
    endtask

    // 0 reads zero, 1 must grow between reads, 2 and 3 must hold
    task automatic check_perf(input result_t r, input string sig);
        int c;
        c = r.core;
        if (r.req.we) begin
            if (r.req.addr[3:0] == 4'h0) begin
                perf_mode[c] = r.req.wdata[1:0];
                perf_seen[c] = 1'b0;
            end
        end else if (perf_mode[c] == 2'd0) begin
            check_value(sig, r.rdata, '0);
        end else if (r.req.addr[2]) begin
            if (perf_seen[c] && perf_mode[c] == 2'd1) begin
                check_value($sformatf("%s above %h", sig, perf_last[c]),
                            data_t'(r.rdata > perf_last[c]), 32'd1);
            end else if (perf_seen[c]) begin
                check_value(sig, r.rdata, perf_last[c]);
            end
            perf_last[c] = r.rdata;
            perf_seen[c] = 1'b1;
        end
    endtask

    initial begin : compare_results
        result_t r;
        region_e reg_exp;
        int      idx;
        string   sig;
        forever begin
            @(posedge clk_i);
            while (results.size() > 0) begin
                r       = results.pop_front();
                reg_exp = expected_region(r.req.addr);
                sig     = $sformatf("dbus_rdata_o[%0d]", r.core);
                case (reg_exp)
                    REGION_DMEM: begin
                        idx = word_index(r.req.addr);
                        if (r.req.we) begin
                            model_mem[idx] = strobe_merge(model_mem[idx], r.req.wdata,
                                                          r.req.wstrb);
                        end else begin
                            check_value(sig, r.rdata, model_mem[idx]);
                        end
                        if (r.lat > DMEM_LAT_MAX) begin
                            n_errors++;
                            $display("core %0d request to %h stalled %0d cycles, over the bound",
                                     r.core, r.req.addr, r.lat);
                        end
                    end
                    REGION_HART: begin
                        if (!r.req.we) begin
                            check_value(sig, r.rdata, expected_hart(r.core));
                        end
                    end
                    REGION_PERF: check_perf(r, sig);
                    default: begin
                        if (!r.req.we) begin
                            check_value(sig, r.rdata, '0);
                        end
                    end
                endcase
                if (reg_exp != REGION_DMEM) begin
                    check_value($sformatf("dbus_stall_o[%0d] cycles", r.core),
                                data_t'(r.lat), 32'd1);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d requests done", cycles, n_done, TOTAL_REQS);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        clk_i      = 1'b0;
        reset_i    = 1'b1;
        n_checks   = 0;
        n_errors   = 0;
        n_done     = 0;
        cores_done = 0;
        for (int c = 0; c < NUM_CORES; c++) begin
            dbus_req[c]  = '0;
            perf_mode[c] = 2'd0;  // control is clear after reset
            perf_last[c] = '0;
            perf_seen[c] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);
        for (int c = 0; c < NUM_CORES; c++) begin
            check_value($sformatf("dbus_stall_o[%0d]", c), data_t'(dbus_stall[c]), '0);
            check_value($sformatf("dbus_rdata_o[%0d]", c), dbus_rdata[c], '0);
        end
        single_core_strobes();
        run_on_all_cores(3);
        run_on_all_cores(4);
        run_on_all_cores(5);
        run_on_all_cores(6);
        while (results.size() > 0) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        $display("checks %0d, errors %0d, requests %0d", n_checks, n_errors, n_done);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== logic/cluster_pkg.sv ====
// shared bus types, memory-port types and address region codes
// imported by every RTL block of the cluster and by the testbench
package cluster_pkg;

    typedef logic [31:0] data_t;  // one bus word
    typedef logic [3:0]  strb_t;  // byte enables, bit n for byte n

    localparam int DMEM_ADDR_W = 12;  // word index, 16 KiB total
    localparam int DMEM_WORDS  = 2 ** DMEM_ADDR_W;

    // selector values seen on address bits 30:28
    localparam logic [2:0] ADDR_SEL_DMEM = 3'b001;
    localparam logic [2:0] ADDR_SEL_VMEM = 3'b010;
    localparam logic [2:0] ADDR_SEL_IO   = 3'b100;  // bit 12 splits perf/hart

    typedef enum logic [1:0] {
        REGION_DMEM = 2'd0,
        REGION_VMEM = 2'd1,
        REGION_PERF = 2'd2,
        REGION_HART = 2'd3
    } region_e;

    // request as presented by one core; zero address means idle
    typedef struct packed {
        logic  we;
        data_t addr;
        data_t wdata;
        strb_t wstrb;
    } dbus_req_t;

    // one access on a data-memory port after arbitration
    typedef struct packed {
        logic                   re;
        logic                   we;
        logic [DMEM_ADDR_W-1:0] idx;    // word index
        data_t                  wdata;
        strb_t                  wstrb;
    } dmem_req_t;

endpackage

// ==== logic/core_port.sv ====
// one core's data-bus port: region decode, data-memory request buffer,
// stall generation and selection of the returned read data
`timescale 1ns/100ps

module core_port (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  cluster_pkg::data_t     hart_idx_i,
    input  cluster_pkg::dbus_req_t req_i,
    output logic                   stall_o,
    output cluster_pkg::data_t     rdata_o,
    output logic                   pend_o,
    output cluster_pkg::dbus_req_t pend_req_o,
    input  logic                   grant_i,
    input  logic                   resp_valid_i,
    input  cluster_pkg::data_t     resp_data_i
);
    import cluster_pkg::*;

    function automatic region_e decode_region(data_t addr);
        region_e r;
        case (addr[30:28])
            ADDR_SEL_DMEM: r = REGION_DMEM;
            ADDR_SEL_VMEM: r = REGION_VMEM;
            ADDR_SEL_IO:   r = addr[12] ? REGION_HART : REGION_PERF;
            default:       r = REGION_VMEM;  // unmapped acts like video
        endcase
        return r;
    endfunction

    region_e   region;
    region_e   region_q;   // region of the request being answered
    logic      new_req;
    logic      dmem_hit;
    logic      pend_q;     // buffered, waiting for a grant
    logic      wait_q;     // granted, data returns this cycle
    logic      perf_we;
    dbus_req_t buf_q;
    data_t     perf_rdata;

    assign region   = decode_region(req_i.addr);
    assign new_req  = (req_i.addr != '0) && !pend_q && !wait_q;  // old request ignored in completion
    assign dmem_hit = new_req && (region == REGION_DMEM);
    assign perf_we  = new_req && (region == REGION_PERF) && req_i.we && (req_i.addr[3:0] == 4'h0);
    assign stall_o  = dmem_hit || pend_q;

    assign pend_o     = pend_q;
    assign pend_req_o = buf_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend_q   <= 1'b0;
            wait_q   <= 1'b0;
            region_q <= REGION_VMEM;  // reads as zero
        end else begin
            if (dmem_hit) begin
                pend_q <= 1'b1;
            end else if (pend_q && grant_i) begin
                pend_q <= 1'b0;
            end
            wait_q <= pend_q && grant_i;
            if (wait_q) begin
                region_q <= REGION_VMEM;
            end else if (!pend_q) begin
                region_q <= region;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dmem_hit) begin
            buf_q <= req_i;
        end
    end

    always_comb begin
        case (region_q)
            REGION_DMEM: rdata_o = resp_valid_i ? resp_data_i : '0;
            REGION_PERF: rdata_o = perf_rdata;
            REGION_HART: rdata_o = hart_idx_i;
            default:     rdata_o = '0;
        endcase
    end

    perf_counter perf_counter_i (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .we_i     (perf_we),
        .sel_hi_i (!req_i.addr[2]),
        .ctrl_i   (req_i.wdata[1:0]),
        .rdata_o  (perf_rdata)
    );

    // the core must hold its request while stalled
    assert property (@(posedge clk_i) disable iff (reset_i) stall_o |=> $stable(req_i));

    // a grant is answered by the arbiter exactly one cycle later
    assert property (@(posedge clk_i) disable iff (reset_i) pend_q && grant_i |=> resp_valid_i);

endmodule

// ==== logic/dmem_arbiter.sv ====
// round-robin arbiter granting up to two buffered core requests per cycle
// onto the two data-memory ports and routing read data back by core
`timescale 1ns/100ps

module dmem_arbiter #(
    parameter int NUM_CORES  = 4,
    parameter int CORE_IDX_W = $clog2(NUM_CORES)
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic [NUM_CORES-1:0]   pend_i,
    input  cluster_pkg::dbus_req_t pend_req_i [NUM_CORES],
    output logic [NUM_CORES-1:0]   grant_o,
    output logic [NUM_CORES-1:0]   resp_valid_o,
    output cluster_pkg::data_t     resp_data_o [NUM_CORES],
    output cluster_pkg::dmem_req_t port_a_o,
    output cluster_pkg::dmem_req_t port_b_o,
    input  cluster_pkg::data_t     rdata_a_i,
    input  cluster_pkg::data_t     rdata_b_i
);
    import cluster_pkg::*;

    function automatic dmem_req_t to_dmem(logic vld, dbus_req_t r);
        dmem_req_t m;
        m.re    = vld && !r.we;
        m.we    = vld && r.we;
        m.idx   = r.addr[DMEM_ADDR_W+1:2];  // byte address to word index
        m.wdata = r.wdata;
        m.wstrb = r.wstrb;
        return m;
    endfunction

    logic [CORE_IDX_W-1:0] rr_ptr_q;  // first core to consider
    logic [CORE_IDX_W-1:0] sel_a;
    logic [CORE_IDX_W-1:0] sel_b;
    logic                  sel_a_vld;
    logic                  sel_b_vld;
    logic [CORE_IDX_W-1:0] resp_a_q;  // core served by port a last cycle
    logic [CORE_IDX_W-1:0] resp_b_q;
    logic                  resp_a_vld_q;
    logic                  resp_b_vld_q;

    // scan from the pointer, first hit to port a, second to port b
    always_comb begin
        logic [CORE_IDX_W-1:0] cand;
        sel_a     = '0;
        sel_b     = '0;
        sel_a_vld = 1'b0;
        sel_b_vld = 1'b0;
        for (int k = 0; k < NUM_CORES; k++) begin
            cand = CORE_IDX_W'((int'(rr_ptr_q) + k) % NUM_CORES);
            if (pend_i[cand]) begin
                if (!sel_a_vld) begin
                    sel_a     = cand;
                    sel_a_vld = 1'b1;
                end else if (!sel_b_vld) begin
                    sel_b     = cand;
                    sel_b_vld = 1'b1;
                end
            end
        end
    end

    assign port_a_o = to_dmem(sel_a_vld, pend_req_i[sel_a]);
    assign port_b_o = to_dmem(sel_b_vld, pend_req_i[sel_b]);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr_q     <= '0;
            resp_a_vld_q <= 1'b0;
            resp_b_vld_q <= 1'b0;
        end else begin
            if (sel_b_vld) begin
                rr_ptr_q <= CORE_IDX_W'((int'(sel_b) + 1) % NUM_CORES);
            end else if (sel_a_vld) begin
                rr_ptr_q <= CORE_IDX_W'((int'(sel_a) + 1) % NUM_CORES);
            end
            resp_a_vld_q <= sel_a_vld;
            resp_b_vld_q <= sel_b_vld;
        end
    end

    always_ff @(posedge clk_i) begin
        resp_a_q <= sel_a;
        resp_b_q <= sel_b;
    end

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_route
        logic hit_a;
        logic hit_b;
        assign grant_o[i] = (sel_a_vld && sel_a == CORE_IDX_W'(i))
                         || (sel_b_vld && sel_b == CORE_IDX_W'(i));
        assign hit_a = resp_a_vld_q && (resp_a_q == CORE_IDX_W'(i));
        assign hit_b = resp_b_vld_q && (resp_b_q == CORE_IDX_W'(i));
        assign resp_valid_o[i] = hit_a || hit_b;
        assign resp_data_o[i]  = hit_a ? rdata_a_i : (hit_b ? rdata_b_i : '0);
    end

    // each port's grant lands on its own core in the grant vector
    assert property (@(posedge clk_i) disable iff (reset_i)
        $countones(grant_o) == int'(sel_a_vld) + int'(sel_b_vld));

endmodule

// ==== logic/dmem_bank.sv ====
// dual-port data memory, byte-strobed writes and registered reads
// both ports share one array; read data appears the cycle after re
`timescale 1ns/100ps

module dmem_bank (
    input  logic                   clk_i,
    input  cluster_pkg::dmem_req_t port_a_i,
    input  cluster_pkg::dmem_req_t port_b_i,
    output cluster_pkg::data_t     rdata_a_o,
    output cluster_pkg::data_t     rdata_b_o
);
    import cluster_pkg::*;

    data_t mem [DMEM_WORDS];

    always_ff @(posedge clk_i) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (port_a_i.we && port_a_i.wstrb[b]) begin
                mem[port_a_i.idx][b*8 +: 8] <= port_a_i.wdata[b*8 +: 8];
            end
            if (port_b_i.we && port_b_i.wstrb[b]) begin
                mem[port_b_i.idx][b*8 +: 8] <= port_b_i.wdata[b*8 +: 8];
            end
        end
        if (port_a_i.re) begin
            rdata_a_o <= mem[port_a_i.idx];  // old data on read-during-write
        end
        if (port_b_i.re) begin
            rdata_b_o <= mem[port_b_i.idx];
        end
    end

    // two cores writing one word in the same cycle would race
    assert property (@(posedge clk_i)
        port_a_i.we && port_b_i.we |-> port_a_i.idx != port_b_i.idx);

endmodule

// ==== logic/mem_cluster.sv ====
// data-memory side of the cluster: one port per core,
// a two-way arbiter and the shared dual-port data memory
`timescale 1ns/100ps

module mem_cluster #(
    parameter int NUM_CORES = 4
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  cluster_pkg::dbus_req_t dbus_req_i   [NUM_CORES],
    output logic [NUM_CORES-1:0]   dbus_stall_o,
    output cluster_pkg::data_t     dbus_rdata_o [NUM_CORES]
);
    import cluster_pkg::*;

    localparam int CORE_IDX_W = $clog2(NUM_CORES);

    logic [NUM_CORES-1:0] pend;
    dbus_req_t            pend_req   [NUM_CORES];
    logic [NUM_CORES-1:0] grant;
    logic [NUM_CORES-1:0] resp_valid;
    data_t                resp_data  [NUM_CORES];
    dmem_req_t            port_a;
    dmem_req_t            port_b;
    data_t                rdata_a;
    data_t                rdata_b;

    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        core_port core_port_i (
            .clk_i        (clk_i),
            .reset_i      (reset_i),
            .hart_idx_i   (data_t'(c)),  // hart index is the core position
            .req_i        (dbus_req_i[c]),
            .stall_o      (dbus_stall_o[c]),
            .rdata_o      (dbus_rdata_o[c]),
            .pend_o       (pend[c]),
            .pend_req_o   (pend_req[c]),
            .grant_i      (grant[c]),
            .resp_valid_i (resp_valid[c]),
            .resp_data_i  (resp_data[c])
        );
    end

    dmem_arbiter #(
        .NUM_CORES  (NUM_CORES),
        .CORE_IDX_W (CORE_IDX_W)
    ) dmem_arbiter_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .pend_i       (pend),
        .pend_req_i   (pend_req),
        .grant_o      (grant),
        .resp_valid_o (resp_valid),
        .resp_data_o  (resp_data),
        .port_a_o     (port_a),
        .port_b_o     (port_b),
        .rdata_a_i    (rdata_a),
        .rdata_b_i    (rdata_b)
    );

    dmem_bank dmem_bank_i (
        .clk_i     (clk_i),
        .port_a_i  (port_a),
        .port_b_i  (port_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

endmodule

// ==== logic/perf_counter.sv ====
// per-core 64-bit cycle counter, controlled by a write to offset 0
// read returns the low or high half one cycle after the request
`timescale 1ns/100ps

module perf_counter (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               we_i,      // control write strobe
    input  logic               sel_hi_i,  // high word when set
    input  logic [1:0]         ctrl_i,
    output cluster_pkg::data_t rdata_o
);

    logic [63:0] count_q;
    logic [1:0]  ctrl_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_q  <= 2'd0;  // clear mode
            rdata_o <= '0;
        end else begin
            if (we_i) begin
                ctrl_q <= ctrl_i;
            end
            rdata_o <= sel_hi_i ? count_q[63:32] : count_q[31:0];
        end
    end

    // 0 clears, 1 counts, 2 and 3 hold
    always_ff @(posedge clk_i) begin
        case (ctrl_q)
            2'd0:    count_q <= '0;
            2'd1:    count_q <= count_q + 64'd1;
            default: count_q <= count_q;
        endcase
    end

endmodule

// ==== tb.f ====
+incdir+bench
logic/cluster_pkg.sv
logic/perf_counter.sv
logic/core_port.sv
logic/dmem_arbiter.sv
logic/dmem_bank.sv
logic/mem_cluster.sv
bench/cluster_tb.sv
